// ==== logic/biu2wb.sv ====
//////////////////////////////////////////////////////////////////////
// core strobe interface to wishbone b3 registered feedback master
// one transfer in flight, retry and lock are not supported
// core holds biu_stb_i until biu_stb_ack_o, write data follows d_ack
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module biu2wb (
  input  wire                       HCLK,
  input  wire                       HRESETn,

  // core side
  input  wire                       biu_stb_i,
  input  wire biu_wb_pkg::biu_req_t biu_req_i,
  input  wire biu_wb_pkg::data_t    biu_d_i,
  output logic                      biu_stb_ack_o, // request taken
  output logic                      biu_d_ack_o,   // write beat done, next data
  output biu_wb_pkg::data_t         biu_q_o,
  output logic                      biu_ack_o,     // one per beat
  output logic                      biu_err_o,

  // wishbone side
  output biu_wb_pkg::wb_req_t       wb_req_o,
  output biu_wb_pkg::data_t         wb_dat_o,
  output logic                      wb_cyc_o,
  output logic                      wb_stb_o,
  input  wire biu_wb_pkg::data_t    wb_dat_i,
  input  wire                       wb_ack_i,
  input  wire                       wb_err_i
);
  import biu_wb_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_BUS
  } st_e;

  st_e        state;
  biu_size_e  size_q;
  biu_burst_e burst_q;
  logic       we_q;
  data_t      dat_q;      // write data of current beat

  addr_t      beat_addr;  // from sequencer
  logic       beat_last;
  logic       accept;
  logic       beat_ack;
  logic       single;

  assign accept   = (state == ST_IDLE) & biu_stb_i;
  assign beat_ack = (state == ST_BUS) & wb_ack_i;
  assign single   = (burst_beats_m1(burst_q) == '0); // single and INCR

  //////////////////////////////////////////////////////////////////////
  // burst address and beat count
  //////////////////////////////////////////////////////////////////////

  biu_burst_addr u_burst_addr (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .load_i       (accept),
    .start_addr_i (biu_req_i.addr),
    .burst_i      (biu_req_i.burst),
    .step_i       (beat_ack),     // address moves only on ack edge
    .addr_o       (beat_addr),
    .last_o       (beat_last)
  );

  //////////////////////////////////////////////////////////////////////
  // fsm
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (biu_stb_i) state <= ST_BUS;                // cyc rises next edge
        end
        ST_BUS: begin
          if (wb_err_i) state <= ST_IDLE;                // abort rest of burst
          else if (wb_ack_i && beat_last) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // transfer attributes, latched with the strobe
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      size_q  <= SIZE_WORD;
      burst_q <= BURST_SINGLE;
      we_q    <= 1'b0;
    end else if (accept) begin
      // bursts always move whole words
      if (burst_beats_m1(biu_req_i.burst) != '0) size_q <= SIZE_WORD;
      else size_q <= biu_req_i.size;
      burst_q <= biu_req_i.burst;
      we_q    <= biu_req_i.we;
    end
  end

  // first beat with the strobe, then whatever the core shows at each ack
  always_ff @(posedge HCLK) begin
    if (accept || (beat_ack && we_q)) dat_q <= biu_d_i;
  end

  //////////////////////////////////////////////////////////////////////
  // wishbone request
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    wb_req_o.adr = {beat_addr[31:2], 2'b00};
    wb_req_o.sel = size_to_sel(size_q, beat_addr[1:0]);
    wb_req_o.we  = we_q;
    wb_req_o.bte = burst_to_bte(burst_q);
    if (single) wb_req_o.cti = CTI_CLASSIC;
    else if (beat_last) wb_req_o.cti = CTI_END;  // tag last beat
    else wb_req_o.cti = CTI_INCR;
  end

  assign wb_dat_o = dat_q;
  assign wb_cyc_o = (state == ST_BUS);
  assign wb_stb_o = (state == ST_BUS); // no idle beats inside a cycle

  //////////////////////////////////////////////////////////////////////
  // core responses
  //////////////////////////////////////////////////////////////////////

  assign biu_stb_ack_o = accept;                          // same cycle as strobe
  assign biu_ack_o     = beat_ack;
  assign biu_d_ack_o   = beat_ack & we_q;
  assign biu_err_o     = (state == ST_BUS) & wb_err_i;
  assign biu_q_o       = wb_dat_i;                        // valid with biu_ack_o

endmodule

`default_nettype wire

// ==== logic/biu_burst_addr.sv ====
//////////////////////////////////////////////////////////////////////
// beat counter and address sequencer for one bridge transfer
// addresses step by one 32-bit word and wraps keep the upper bits
// load_i and step_i in the same cycle is not expected
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module biu_burst_addr (
  input  wire                         HCLK,
  input  wire                         HRESETn,
  input  wire                         load_i,       // new transfer accepted
  input  wire biu_wb_pkg::addr_t      start_addr_i,
  input  wire biu_wb_pkg::biu_burst_e burst_i,
  input  wire                         step_i,       // current beat acknowledged
  output biu_wb_pkg::addr_t           addr_o,
  output logic                        last_o
);
  import biu_wb_pkg::*;

  addr_t      addr_q;
  addr_t      lin_addr;  // next word without wrap
  addr_t      nxt_addr;
  beat_cnt_t  cnt_q;     // beats left minus one
  biu_burst_e burst_q;

  //////////////////////////////////////////////////////////////////////
  // next address
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    lin_addr = {addr_q[31:2] + 30'd1, 2'b00};
    case (burst_q)
      BURST_WRAP4:  nxt_addr = {addr_q[31:4], lin_addr[3:0]}; // 16 byte window
      BURST_WRAP8:  nxt_addr = {addr_q[31:5], lin_addr[4:0]}; // 32 bytes
      BURST_WRAP16: nxt_addr = {addr_q[31:6], lin_addr[5:0]}; // 64 bytes
      default:      nxt_addr = lin_addr;
    endcase
  end

  // byte address of the current beat
  always_ff @(posedge HCLK) begin
    if (load_i) addr_q <= start_addr_i;
    else if (step_i) addr_q <= nxt_addr;
  end

  //////////////////////////////////////////////////////////////////////
  // beat counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      cnt_q   <= '0;
      burst_q <= BURST_SINGLE;
    end else if (load_i) begin
      cnt_q   <= burst_beats_m1(burst_i);
      burst_q <= burst_i;
    end else if (step_i && cnt_q != '0) begin
      cnt_q   <= cnt_q - beat_cnt_t'(1); // hold at zero after last
    end
  end

  assign addr_o = addr_q;
  assign last_o = (cnt_q == '0);

endmodule

`default_nettype wire

// ==== logic/biu_wb_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types and helpers for the biu to wishbone bridge
// 32-bit data and byte addresses only, no 64-bit support
// bursts move whole words, sub-word sizes apply to singles only
//////////////////////////////////////////////////////////////////////

`default_nettype none

package biu_wb_pkg;

  localparam int MEM_WORDS = 256;               // target depth in words
  localparam int MEM_IDX_W = $clog2(MEM_WORDS); // word index width

  typedef logic [31:0] addr_t;     // byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  sel_t;      // one bit per byte lane
  typedef logic [3:0]  beat_cnt_t; // beats left minus one

  typedef enum logic [2:0] {
    SIZE_BYTE = 3'd0,
    SIZE_HALF = 3'd1,
    SIZE_WORD = 3'd2
  } biu_size_e;

  // core burst encoding, INCR is handled as a single
  typedef enum logic [2:0] {
    BURST_SINGLE = 3'd0,
    BURST_INCR   = 3'd1,
    BURST_WRAP4  = 3'd2,
    BURST_INCR4  = 3'd3,
    BURST_WRAP8  = 3'd4,
    BURST_INCR8  = 3'd5,
    BURST_WRAP16 = 3'd6,
    BURST_INCR16 = 3'd7
  } biu_burst_e;

  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    CTI_INCR    = 3'b010, // incrementing burst, more beats follow
    CTI_END     = 3'b111  // last beat of the burst
  } wb_cti_e;

  typedef enum logic [1:0] {
    BTE_LINEAR = 2'b00,
    BTE_WRAP4  = 2'b01,
    BTE_WRAP8  = 2'b10,
    BTE_WRAP16 = 2'b11
  } wb_bte_e;

  typedef struct packed {
    addr_t      addr;
    biu_size_e  size;
    biu_burst_e burst;
    logic       we;
  } biu_req_t;

  typedef struct packed {
    addr_t   adr;   // word aligned
    sel_t    sel;
    logic    we;
    wb_cti_e cti;
    wb_bte_e bte;
  } wb_req_t;

  function automatic beat_cnt_t burst_beats_m1(input biu_burst_e burst);
    case (burst)
      BURST_WRAP4,  BURST_INCR4:  return beat_cnt_t'(3);
      BURST_WRAP8,  BURST_INCR8:  return beat_cnt_t'(7);
      BURST_WRAP16, BURST_INCR16: return beat_cnt_t'(15);
      default:                    return '0; // single and INCR
    endcase
  endfunction

  function automatic wb_bte_e burst_to_bte(input biu_burst_e burst);
    case (burst)
      BURST_WRAP4:  return BTE_WRAP4;
      BURST_WRAP8:  return BTE_WRAP8;
      BURST_WRAP16: return BTE_WRAP16;
      default:      return BTE_LINEAR;
    endcase
  endfunction

  // byte lanes from size and low address bits, little endian
  function automatic sel_t size_to_sel(input biu_size_e size, input logic [1:0] offs);
    case (size)
      SIZE_BYTE: return sel_t'(4'b0001 << offs);
      SIZE_HALF: return offs[1] ? 4'b1100 : 4'b0011;
      default:   return 4'b1111;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== logic/biu_wb_top.sv ====
//////////////////////////////////////////////////////////////////////
// bridge plus memory target, one wishbone master and one slave
// WAIT_STATES goes to the target, 0 to 3
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module biu_wb_top #(
  parameter int WAIT_STATES = 1
) (
  input  wire                       HCLK,
  input  wire                       HRESETn,
  input  wire                       biu_stb_i,
  input  wire biu_wb_pkg::biu_req_t biu_req_i,
  input  wire biu_wb_pkg::data_t    biu_d_i,
  output logic                      biu_stb_ack_o,
  output logic                      biu_d_ack_o,
  output biu_wb_pkg::data_t         biu_q_o,
  output logic                      biu_ack_o,
  output logic                      biu_err_o
);
  import biu_wb_pkg::*;

  // wishbone bus between bridge and target
  wb_req_t wb_req;
  data_t   wb_dat_w;    // master to slave
  data_t   wb_dat_r;    // slave to master
  logic    wb_cyc;
  logic    wb_stb;
  logic    wb_ack;
  logic    wb_err;

  biu2wb u_biu2wb (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (biu_stb_i),
    .biu_req_i     (biu_req_i),
    .biu_d_i       (biu_d_i),
    .biu_stb_ack_o (biu_stb_ack_o),
    .biu_d_ack_o   (biu_d_ack_o),
    .biu_q_o       (biu_q_o),
    .biu_ack_o     (biu_ack_o),
    .biu_err_o     (biu_err_o),
    .wb_req_o      (wb_req),
    .wb_dat_o      (wb_dat_w),
    .wb_cyc_o      (wb_cyc),
    .wb_stb_o      (wb_stb),
    .wb_dat_i      (wb_dat_r),
    .wb_ack_i      (wb_ack),
    .wb_err_i      (wb_err)
  );

  wb_mem_target #(
    .WAIT_STATES (WAIT_STATES)
  ) u_mem (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_req_i (wb_req),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack),
    .wb_err_o (wb_err)
  );

endmodule

`default_nettype wire

// ==== logic/wb_mem_target.sv ====
//////////////////////////////////////////////////////////////////////
// wishbone memory target, MEM_WORDS deep, 32-bit wide
// WAIT_STATES from 0 to 3, ack or err is registered and lasts a cycle
// cti and bte are not decoded, every beat carries its own address
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wb_mem_target #(
  parameter int WAIT_STATES = 0
) (
  input  wire                      HCLK,
  input  wire                      HRESETn,
  input  wire                      wb_cyc_i,
  input  wire                      wb_stb_i,
  input  wire biu_wb_pkg::wb_req_t wb_req_i,
  input  wire biu_wb_pkg::data_t   wb_dat_i,
  output biu_wb_pkg::data_t        wb_dat_o,
  output logic                     wb_ack_o,
  output logic                     wb_err_o
);
  import biu_wb_pkg::*;

  data_t                 mem [MEM_WORDS];   // no reset on the array

  logic [1:0]            wait_cnt;          // cycles spent on this beat
  logic                  req_pend;          // beat seen, not yet answered
  logic                  beat_done;         // answer goes out next edge
  logic                  in_range;
  logic [MEM_IDX_W-1:0]  mem_idx;

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  assign mem_idx  = wb_req_i.adr[2 +: MEM_IDX_W];
  assign in_range = (wb_req_i.adr < addr_t'(MEM_WORDS * 4));

  // the beat being answered is not seen again while ack is high,
  // the master moves the address on that same edge
  assign req_pend  = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;
  assign beat_done = req_pend & (wait_cnt == 2'(WAIT_STATES));

  //////////////////////////////////////////////////////////////////////
  // wait states and response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wait_cnt <= 2'd0;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= 1'b0;   // single cycle pulses
      wb_err_o <= 1'b0;
      if (beat_done) begin
        wait_cnt <= 2'd0;
        if (in_range) wb_ack_o <= 1'b1;
        else wb_err_o <= 1'b1;    // outside the array
      end else if (req_pend) begin
        wait_cnt <= wait_cnt + 2'd1;
      end else begin
        wait_cnt <= 2'd0;         // idle or answering
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  // byte lane writes, only when the beat is accepted
  always_ff @(posedge HCLK) begin
    if (beat_done && in_range && wb_req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (wb_req_i.sel[b]) mem[mem_idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
      end
    end
  end

  // reads return the full word, the master picks the lanes
  always_ff @(posedge HCLK) begin
    if (beat_done && in_range && !wb_req_i.we) wb_dat_o <= mem[mem_idx];
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds biu_wb_tb with verilator, runs it, and checks sim.log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -j 0 --top-module biu_wb_tb -f src.f \
  -o Vbiu_wb_tb > build.log 2>&1 \
  && ./obj_dir/Vbiu_wb_tb > sim.log 2>&1 \
  || { cat build.log; echo "build or run returned an error"; }

grep -q "Simulation completed successfully" sim.log 2>/dev/null \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL, see sim.log"; exit 1; }

// ==== src.f ====
logic/biu_wb_pkg.sv
logic/biu_burst_addr.sv
logic/biu2wb.sv
logic/wb_mem_target.sv
logic/biu_wb_top.sv
tests/biu_wb_tb.sv

// ==== tests/biu_wb_tb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for biu_wb_top with the target at WAIT_STATES = 1
// a shadow array predicts every read
// every wait is bounded by TIMEOUT cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module biu_wb_tb;
  import biu_wb_pkg::*;

  localparam int    TIMEOUT = 40;                       // cycles per wait
  localparam addr_t MEM_END = addr_t'(MEM_WORDS * 4);   // first bad byte address

  logic     HCLK;
  logic     HRESETn;
  logic     biu_stb_i;
  biu_req_t biu_req_i;
  data_t    biu_d_i;
  logic     biu_stb_ack_o;
  logic     biu_d_ack_o;
  data_t    biu_q_o;
  logic     biu_ack_o;
  logic     biu_err_o;

  data_t      shadow [MEM_WORDS];   // expected memory contents
  data_t      wdata  [16];          // write beats of current transfer
  data_t      rdata  [16];          // read beats captured at each ack
  int         n_acks;
  logic       got_err;
  biu_burst_e incr_list [3] = '{BURST_INCR4, BURST_INCR8, BURST_INCR16};
  biu_burst_e wrap_list [3] = '{BURST_WRAP4, BURST_WRAP8, BURST_WRAP16};

  biu_wb_top #(
    .WAIT_STATES (1)
  ) dut (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (biu_stb_i),
    .biu_req_i     (biu_req_i),
    .biu_d_i       (biu_d_i),
    .biu_stb_ack_o (biu_stb_ack_o),
    .biu_d_ack_o   (biu_d_ack_o),
    .biu_q_o       (biu_q_o),
    .biu_ack_o     (biu_ack_o),
    .biu_err_o     (biu_err_o)
  );

  initial begin
    HCLK = 1'b0;
    forever #50 HCLK = ~HCLK;   // 100 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // checks and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input data_t exp, input data_t act);
    assert (act === exp) else begin
      $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1, "first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: no %s within %0d cycles", what, TIMEOUT);
    $display("Simulation failed");
    $fatal(1, "wait timed out");
  endtask

  // no response may show while the core is quiet
  task automatic expect_idle(input int cycles);
    repeat (cycles) begin
      @(posedge HCLK);
      check_value("biu_stb_ack_o", '0, data_t'(biu_stb_ack_o));
      check_value("biu_ack_o", '0, data_t'(biu_ack_o));
      check_value("biu_d_ack_o", '0, data_t'(biu_d_ack_o));
      check_value("biu_err_o", '0, data_t'(biu_err_o));
    end
  endtask

  // beat k address with wraps kept inside their 16/32/64 byte window
  function automatic addr_t expected_addr(input addr_t start, input biu_burst_e burst,
                                          input int k);
    addr_t lin;
    addr_t win;
    lin = {start[31:2], 2'b00} + addr_t'(4 * k);
    case (burst)
      BURST_WRAP4:  win = addr_t'(15);
      BURST_WRAP8:  win = addr_t'(31);
      BURST_WRAP16: win = addr_t'(63);
      default:      win = '0;            // linear
    endcase
    if (win == '0) return lin;
    return ({start[31:2], 2'b00} & ~win) | (lin & win);
  endfunction

  function automatic int word_idx(input addr_t a);
    return int'(a[31:2]);
  endfunction

  // word aligned address that leaves room words free above it
  function automatic addr_t rand_word_addr(input int room);
    int idx;
    idx = int'($urandom % (MEM_WORDS - room));
    return addr_t'(idx * 4);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // core side driver
  //////////////////////////////////////////////////////////////////////

  task automatic run_transfer(input addr_t addr, input biu_size_e size,
                              input biu_burst_e burst, input logic we, input int nbeats);
    int cnt;
    int beat;
    @(negedge HCLK);
    biu_stb_i       = 1'b1;
    biu_req_i.addr  = addr;
    biu_req_i.size  = size;
    biu_req_i.burst = burst;
    biu_req_i.we    = we;
    biu_d_i         = wdata[0];
    cnt = 0;
    do begin                            // held until the bridge takes it
      @(posedge HCLK);
      check_value("biu_ack_o", '0, data_t'(biu_ack_o));
      cnt++;
      if (cnt > TIMEOUT) report_timeout("biu_stb_ack_o");
    end while (!biu_stb_ack_o);
    @(negedge HCLK);
    biu_stb_i = 1'b0;
    biu_d_i   = wdata[1];               // beat 0 data went in with the strobe
    n_acks  = 0;
    got_err = 1'b0;
    beat    = 0;
    cnt     = 0;
    while (beat < nbeats && !got_err) begin
      @(posedge HCLK);
      if (biu_err_o) begin
        got_err = 1'b1;                 // rest of burst dropped
      end else if (biu_ack_o) begin
        check_value("biu_d_ack_o", data_t'(we), data_t'(biu_d_ack_o));
        rdata[beat] = biu_q_o;
        beat++;
        n_acks++;
        cnt = 0;
        @(negedge HCLK);
        biu_d_i = wdata[(beat + 1) % 16]; // stays one beat ahead
      end else begin
        cnt++;
        if (cnt > TIMEOUT) report_timeout("biu_ack_o or biu_err_o");
      end
    end
  endtask

  // runs one request and checks acks, error, data and shadow
  task automatic verify_transfer(input addr_t addr, input biu_size_e size,
                                 input biu_burst_e burst, input logic we);
    int    nbeats;
    int    good;     // beats below the end of memory
    addr_t a;
    sel_t  sel;
    nbeats = int'(burst_beats_m1(burst)) + 1;
    good   = 0;
    while (good < nbeats && expected_addr(addr, burst, good) < MEM_END) good++;
    foreach (wdata[k]) wdata[k] = $urandom;
    run_transfer(addr, size, burst, we, nbeats);
    check_value("biu_ack_o count", data_t'(good), data_t'(n_acks));
    check_value("biu_err_o", data_t'(good < nbeats), data_t'(got_err));
    sel = (nbeats == 1) ? size_to_sel(size, addr[1:0]) : 4'hf; // bursts are words
    for (int k = 0; k < good; k++) begin
      a = expected_addr(addr, burst, k);
      if (we) begin
        for (int b = 0; b < 4; b++) begin
          if (sel[b]) shadow[word_idx(a)][8*b +: 8] = wdata[k][8*b +: 8];
        end
      end else begin
        check_value($sformatf("biu_q_o beat %0d at %h", k, a), shadow[word_idx(a)], rdata[k]);
      end
    end
    expect_idle(3);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    addr_t a;
    int    w;
    HRESETn   = 1'b0;
    biu_stb_i = 1'b0;
    biu_req_i = '0;
    biu_d_i   = '0;
    void'($urandom(7));
    repeat (3) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
    expect_idle(5);                     // quiet after reset

    // whole memory filled by INCR16 writes
    for (int blk = 0; blk < MEM_WORDS / 16; blk++) begin
      verify_transfer(addr_t'(blk * 64), SIZE_WORD, BURST_INCR16, 1'b1);
    end

    repeat (16) begin
      a = rand_word_addr(0);
      verify_transfer(a, SIZE_WORD, BURST_SINGLE, 1'b1);
      verify_transfer(a, SIZE_WORD, BURST_SINGLE, 1'b0);
    end
    a = rand_word_addr(0);
    verify_transfer(a, SIZE_WORD, BURST_INCR, 1'b1);  // one beat only
    verify_transfer(a, SIZE_WORD, BURST_INCR, 1'b0);

    // byte and half lanes with the merged word read back
    for (int offs = 0; offs < 4; offs++) begin
      a = rand_word_addr(0);
      verify_transfer(a + addr_t'(offs), SIZE_BYTE, BURST_SINGLE, 1'b1);
      verify_transfer(a, SIZE_WORD, BURST_SINGLE, 1'b0);
      verify_transfer(a + addr_t'(offs), SIZE_HALF, BURST_SINGLE, 1'b1);
      verify_transfer(a, SIZE_WORD, BURST_SINGLE, 1'b0);
    end

    foreach (incr_list[i]) begin
      repeat (3) begin
        a = rand_word_addr(16);
        verify_transfer(a, SIZE_WORD, incr_list[i], 1'b1);
        verify_transfer(a, SIZE_WORD, incr_list[i], 1'b0);
      end
    end

    // wraps start inside the window and never on its base
    foreach (wrap_list[i]) begin
      w = int'(burst_beats_m1(wrap_list[i])) + 1;
      repeat (3) begin
        a = rand_word_addr(0) & ~addr_t'(4 * w - 1);
        a = a | addr_t'(4 * (1 + int'($urandom % (w - 1))));
        verify_transfer(a, SIZE_WORD, wrap_list[i], 1'b0);
      end
      verify_transfer(a, SIZE_WORD, wrap_list[i], 1'b1);
      verify_transfer(a, SIZE_WORD, wrap_list[i], 1'b0);
    end

    // out of range singles and bursts that run off the end
    verify_transfer(MEM_END, SIZE_WORD, BURST_SINGLE, 1'b0);
    verify_transfer(MEM_END + addr_t'(8), SIZE_WORD, BURST_SINGLE, 1'b1);
    verify_transfer(addr_t'(8), SIZE_WORD, BURST_SINGLE, 1'b0);       // aliased index intact
    verify_transfer(MEM_END - addr_t'(12), SIZE_WORD, BURST_INCR8, 1'b1);
    verify_transfer(MEM_END - addr_t'(8), SIZE_WORD, BURST_INCR4, 1'b0);
    verify_transfer(MEM_END - addr_t'(64), SIZE_WORD, BURST_INCR16, 1'b0);
    verify_transfer(addr_t'(36), SIZE_WORD, BURST_WRAP16, 1'b0);      // normal again

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
